//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = secded_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/secded_input.txt
// plaintext numbits errpos0 errpos1 expected correctable uncorrectable
// data words in hex, numbits 0 none 1 single 2 double, positions in decimal
0000000000000000 0 0 0 0000000000000000 0 0
ffffffffffffffff 0 0 0 ffffffffffffffff 0 0
1c7e3a9d05b2f468 0 0 0 1c7e3a9d05b2f468 0 0
8b3d52e0f19a6c47 0 5 9 8b3d52e0f19a6c47 0 0
2d6b91f4c03ae875 0 0 0 2d6b91f4c03ae875 0 0
c4e8173a9b2d60f1 1 9 0 c4e8173a9b2d60f1 1 0
5e29c0d4a7813bf6 1 0 0 5e29c0d4a7813bf6 1 0
0000000000000000 1 1 0 0000000000000000 1 0
ffffffffffffffff 1 2 0 ffffffffffffffff 1 0
3fa8610bc4d2975e 1 4 0 3fa8610bc4d2975e 1 0
d21c9b7040e8a53f 1 8 0 d21c9b7040e8a53f 1 0
6a0f3e85b71dc294 1 16 0 6a0f3e85b71dc294 1 0
93e4a7d2085c1f6b 1 32 0 93e4a7d2085c1f6b 1 0
0000000000000000 1 64 0 0000000000000000 1 0
ffffffffffffffff 1 3 0 ffffffffffffffff 1 0
0123456789abcdef 1 71 0 0123456789abcdef 1 0
e7b0593cd4a1862f 1 37 0 e7b0593cd4a1862f 1 0
4c91f02a6e3db758 1 50 0 4c91f02a6e3db758 1 0
a5a5a5a55a5a5a5a 1 72 0 a5a5a5a55a5a5a5a 0 0
0f1e2d3c4b5a6978 1 127 0 0f1e2d3c4b5a6978 0 0
0000000000000000 2 0 3 0000000000000001 0 1
ffffffffffffffff 2 3 5 fffffffffffffffc 0 1
71c6d28e3fb0a945 2 1 2 71c6d28e3fb0a945 0 1
0000000000000000 2 71 64 8000000000000000 0 1
0123456789abcdef 2 10 40 0123456589abcdcf 0 1
b83f07e6a1d94c52 2 0 29 b83f07e6a1594c52 0 1
96d3e1072fa84b5c 0 0 0 96d3e1072fa84b5c 0 0

//--- bench/secded_properties.sv
`timescale 1ns/1ns

// Timing and flag rules on the top level ports
module secded_properties (
	input logic clk,
	input logic arst_n,
	input logic plaintext_valid,
	input logic decoded_valid,
	input logic correctable_err,
	input logic uncorrectable_err
);

	// Three register stages between plaintext and decoded
	property valid_latency;
		@(posedge clk) disable iff (!arst_n)
			decoded_valid == $past(plaintext_valid, 3);
	endproperty

	// One flip and two flips exclude each other
	property flags_exclusive;
		@(posedge clk) disable iff (!arst_n)
			!(correctable_err && uncorrectable_err);
	endproperty

	// Flags only travel with a valid word
	property flags_need_valid;
		@(posedge clk) disable iff (!arst_n)
			!decoded_valid |-> (!correctable_err && !uncorrectable_err);
	endproperty

	latency_check: assert property (valid_latency)
		else $error("decoded_valid does not follow plaintext_valid by three cycles");

	exclusive_check: assert property (flags_exclusive)
		else $error("correctable_err and uncorrectable_err are high together");

	idle_flags_check: assert property (flags_need_valid)
		else $error("An error flag is high while decoded_valid is low");

endmodule

bind secded_top secded_properties props (
	.clk               (clk),
	.arst_n            (arst_n),
	.plaintext_valid   (plaintext_valid),
	.decoded_valid     (decoded_valid),
	.correctable_err   (correctable_err),
	.uncorrectable_err (uncorrectable_err)
);

//--- bench/secded_tb.sv
`timescale 1ns/1ns

module secded_tb;

	localparam int PERIOD = 40;
	// Vectors streamed before reset hits the running pipeline
	// The result leaving the decoder at that moment carries correctable_err
	localparam int RESET_AFTER = 10;

	typedef struct {
		secded_pkg::data_t      plain;
		secded_pkg::err_count_t numbits;
		secded_pkg::bit_pos_t   pos0;
		secded_pkg::bit_pos_t   pos1;
		secded_pkg::data_t      want_data;
		logic                   want_corr;
		logic                   want_uncorr;
	} vector_t;

	logic                   clk;
	logic                   arst_n;
	secded_pkg::data_t      plaintext;
	logic                   plaintext_valid;
	secded_pkg::err_count_t numbits;
	secded_pkg::bit_pos_t   errpos0;
	secded_pkg::bit_pos_t   errpos1;
	secded_pkg::data_t      decoded;
	logic                   decoded_valid;
	logic                   correctable_err;
	logic                   uncorrectable_err;

	vector_t vectors[$];
	// Indices of vectors whose result is still in the pipeline
	int      pending[$];
	bit      vectors_loaded;
	int      data_errors;
	int      flag_errors;
	int      other_errors;
	int      checked;

	secded_top UUT (
		.clk               (clk),
		.arst_n            (arst_n),
		.plaintext         (plaintext),
		.plaintext_valid   (plaintext_valid),
		.numbits           (numbits),
		.errpos0           (errpos0),
		.errpos1           (errpos1),
		.decoded           (decoded),
		.decoded_valid     (decoded_valid),
		.correctable_err   (correctable_err),
		.uncorrectable_err (uncorrectable_err)
	);

	always #(PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Vector file and compare tasks

	task automatic load_vectors;
		int      fd;
		int      n;
		string   line;
		vector_t v;
		int      nb;
		int      p0;
		int      p1;
		int      corr;
		int      uncorr;
		fd = $fopen("bench/secded_input.txt", "r");
		if (fd == 0) begin
			$display("The vector file could not be opened");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			// Skip blank lines and the column notes
			if (n > 1 && line.substr(0, 1) != "//") begin
				n = $sscanf(line, "%h %d %d %d %h %d %d",
					v.plain, nb, p0, p1, v.want_data, corr, uncorr);
				if (n == 7) begin
					v.numbits = secded_pkg::err_count_t'(nb);
					v.pos0 = secded_pkg::bit_pos_t'(p0);
					v.pos1 = secded_pkg::bit_pos_t'(p1);
					v.want_corr = corr[0];
					v.want_uncorr = uncorr[0];
					vectors.push_back(v);
				end else begin
					$display("A line of the vector file could not be parsed");
					other_errors++;
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic check_data(input secded_pkg::data_t got, input secded_pkg::data_t want,
			input int idx);
		if (got !== want) begin
			$display("Error: decoded = %h, expected %h (vector %0d)", got, want, idx);
			data_errors++;
		end
	endtask

	task automatic check_flags(input logic got_corr, input logic got_uncorr,
			input logic want_corr, input logic want_uncorr, input int idx);
		if (got_corr !== want_corr) begin
			$display("Error: correctable_err = %h, expected %h (vector %0d)",
				got_corr, want_corr, idx);
			flag_errors++;
		end
		if (got_uncorr !== want_uncorr) begin
			$display("Error: uncorrectable_err = %h, expected %h (vector %0d)",
				got_uncorr, want_uncorr, idx);
			flag_errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	// Plaintext of vector i goes out together with the error controls of vector i-1
	task automatic stream_vectors(input int first, input int last);
		for (int i = first; i <= last + 1; i++) begin
			@(posedge clk);
			#2;
			plaintext_valid = (i <= last);
			if (i <= last) begin
				plaintext = vectors[i].plain;
				pending.push_back(i);
			end
			numbits = (i > first) ? vectors[i - 1].numbits : secded_pkg::ERR_NONE;
			errpos0 = (i > first) ? vectors[i - 1].pos0 : '0;
			errpos1 = (i > first) ? vectors[i - 1].pos1 : '0;
		end
	endtask

	task automatic apply_mid_reset;
		@(posedge clk);
		#2;
		arst_n = 1'b0;
		// Words still in flight are lost
		pending.delete();
		#1;
		if (decoded_valid !== 1'b0 || correctable_err !== 1'b0 || uncorrectable_err !== 1'b0) begin
			$display("Reset during the stream left decoded_valid or a flag high");
			other_errors++;
		end
		repeat (2) @(posedge clk);
		#2;
		arst_n = 1'b1;
	endtask

	task automatic report_and_finish;
		$display("Results checked %0d, data errors %0d, flag errors %0d, other errors %0d",
			checked, data_errors, flag_errors, other_errors);
		if (data_errors + flag_errors + other_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Result monitor sampled mid-cycle

	always @(negedge clk) begin : monitor_results
		int idx;
		if (arst_n && decoded_valid) begin
			if (pending.size() == 0) begin
				$display("A result came out with no vector waiting for it");
				other_errors++;
			end else begin
				idx = pending.pop_front();
				check_data(decoded, vectors[idx].want_data, idx);
				check_flags(correctable_err, uncorrectable_err,
					vectors[idx].want_corr, vectors[idx].want_uncorr, idx);
				checked++;
			end
		end
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		plaintext = '0;
		plaintext_valid = 1'b0;
		numbits = secded_pkg::ERR_NONE;
		errpos0 = '0;
		errpos1 = '0;
		load_vectors();
		vectors_loaded = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		arst_n = 1'b1;
		if (vectors.size() > RESET_AFTER) begin
			stream_vectors(0, RESET_AFTER - 1);
			apply_mid_reset();
			stream_vectors(RESET_AFTER, vectors.size() - 1);
		end else begin
			$display("Too few vectors were read to run the stream");
			other_errors++;
		end
		numbits = secded_pkg::ERR_NONE;
		// Drain the pipeline
		while (pending.size() != 0)
			@(negedge clk);
		repeat (2) @(posedge clk);
		report_and_finish();
	end

	// Watchdog with a limit that grows with the number of vectors
	initial begin : watchdog
		wait (vectors_loaded);
		#((vectors.size() + 20) * PERIOD);
		$display("Watchdog expired before all results came back");
		other_errors++;
		report_and_finish();
	end

endmodule

//--- verilog.f
+incdir+verilog
verilog/secded_pkg.sv
verilog/secded_encoder.sv
verilog/error_injector.sv
verilog/secded_decoder.sv
verilog/secded_top.sv
bench/secded_properties.sv
bench/secded_tb.sv

//--- verilog/error_injector.sv
`timescale 1ns/1ns
`include "secded_consts.svh"

// Fault injection stage between encoder and decoder
// Corrupts zero, one or two codeword bits on request
module error_injector (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   valid_in,
	input  secded_pkg::codeword_t  codeword_in,
	input  secded_pkg::err_count_t numbits,
	input  secded_pkg::bit_pos_t   errpos0,
	input  secded_pkg::bit_pos_t   errpos1,
	output logic                   valid_out,
	output secded_pkg::codeword_t  codeword_out
);

	//////////////////////////////////////////////////////////////////////
	// Flip mask

	// Upper limit of a usable position
	localparam secded_pkg::bit_pos_t LAST_POS = secded_pkg::bit_pos_t'(`SECDED_CODE_BITS - 1);

	secded_pkg::codeword_t flip_mask;

	always_comb begin
		flip_mask = '0;

		// First position used for both single and double
		if (numbits != secded_pkg::ERR_NONE && errpos0 <= LAST_POS)
			flip_mask[errpos0] = 1'b1;

		// Second position only for double
		// XOR so that the same index twice leaves the bit as it was
		if (numbits == secded_pkg::ERR_DOUBLE && errpos1 <= LAST_POS)
			flip_mask[errpos1] = flip_mask[errpos1] ^ 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Output register

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
		end
	end

	// Corrupted word, loaded alongside its valid
	always_ff @(posedge clk) begin
		if (valid_in) begin
			codeword_out <= codeword_in ^ flip_mask;
		end
	end

endmodule

//--- verilog/secded_consts.svh
`ifndef SECDED_CONSTS_SVH
`define SECDED_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Code geometry for the 64-bit SEC-DED channel

// Payload width
`define SECDED_DATA_BITS 64

// Hamming check bits at the power-of-two positions 1 to 64
`define SECDED_HAMMING_BITS 7

// Hamming bits plus the overall parity bit at position 0
`define SECDED_CHECK_BITS (`SECDED_HAMMING_BITS + 1)

// Full codeword, 72 bits
`define SECDED_CODE_BITS (`SECDED_DATA_BITS + `SECDED_CHECK_BITS)

`endif

//--- verilog/secded_decoder.sv
`timescale 1ns/1ns
`include "secded_consts.svh"

// SEC-DED decoder stage
// Fixes one flipped bit, reports two, and hands back the data word
module secded_decoder (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  valid_in,
	input  secded_pkg::codeword_t data_in,
	output logic                  valid_out,
	output secded_pkg::data_t     data_out,
	output logic                  correctable_err,
	output logic                  uncorrectable_err
);

	//////////////////////////////////////////////////////////////////////
	// Syndrome and parity check

	// Highest index that exists in the codeword
	localparam secded_pkg::bit_pos_t LAST_POS = secded_pkg::bit_pos_t'(`SECDED_CODE_BITS - 1);

	secded_pkg::bit_pos_t syndrome;
	logic                 parity_bad;

	always_comb begin
		syndrome = '0;

		// Syndrome bit i re-checks everything parity bit i covered
		// This time the check bit itself is included
		for (int i = 0; i < `SECDED_HAMMING_BITS; i++) begin
			for (int p = 1; p < `SECDED_CODE_BITS; p++) begin
				if (p[i])
					syndrome[i] = syndrome[i] ^ data_in[p];
			end
		end

		// Whole word including bit 0 should have even parity
		parity_bad = ^data_in;
	end

	//////////////////////////////////////////////////////////////////////
	// Classification

	logic single_err;
	logic double_err;

	always_comb begin
		single_err = 1'b0;
		double_err = 1'b0;

		if (parity_bad) begin
			// Odd number of flips is taken as one
			// A syndrome past the last position cannot come from one flip
			if (syndrome <= LAST_POS)
				single_err = 1'b1;
			else
				double_err = 1'b1;
		end else if (syndrome != '0) begin
			// Parity still even but the Hamming checks disagree
			double_err = 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Correction and data extraction

	secded_pkg::data_t data_next;

	always_comb begin
		secded_pkg::codeword_t fixed;
		int d;

		fixed = data_in;
		d = 0;

		// Syndrome gives the index of the bad bit
		// Index 0 is the overall parity bit, which carries no data
		if (single_err)
			fixed[syndrome] = ~fixed[syndrome];

		// Double errors fall through here with the data left as received
		data_next = '0;
		for (int p = 1; p < `SECDED_CODE_BITS; p++) begin
			if ((p & (p - 1)) != 0) begin
				data_next[d] = fixed[p];
				d++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output register

	// Flags only rise together with a valid word
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_out         <= 1'b0;
			correctable_err   <= 1'b0;
			uncorrectable_err <= 1'b0;
		end else begin
			valid_out         <= valid_in;
			correctable_err   <= valid_in && single_err;
			uncorrectable_err <= valid_in && double_err;
		end
	end

	// Data word
	always_ff @(posedge clk) begin
		if (valid_in) begin
			data_out <= data_next;
		end
	end

endmodule

//--- verilog/secded_encoder.sv
`timescale 1ns/1ns
`include "secded_consts.svh"

// SEC-DED encoder stage
// One register stage between data word and codeword
module secded_encoder (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  valid_in,
	input  secded_pkg::data_t     data_in,
	output logic                  valid_out,
	output secded_pkg::codeword_t data_out
);

	//////////////////////////////////////////////////////////////////////
	// Codeword construction

	secded_pkg::codeword_t code_next;

	always_comb begin
		secded_pkg::codeword_t placed;
		logic [`SECDED_HAMMING_BITS-1:0] hamming;
		int d;

		placed = '0;
		hamming = '0;
		d = 0;

		// Scatter data into every position that is not a power of two
		// Position 0 is skipped since it belongs to the overall parity
		for (int p = 1; p < `SECDED_CODE_BITS; p++) begin
			if ((p & (p - 1)) != 0) begin
				placed[p] = data_in[d];
				d++;
			end
		end

		// Hamming parity i covers every position with index bit i set
		// Check positions are still zero here so they add nothing
		for (int i = 0; i < `SECDED_HAMMING_BITS; i++) begin
			for (int p = 1; p < `SECDED_CODE_BITS; p++) begin
				if (p[i])
					hamming[i] = hamming[i] ^ placed[p];
			end
		end

		// Drop the check bits into their power-of-two slots
		for (int i = 0; i < `SECDED_HAMMING_BITS; i++)
			placed[1 << i] = hamming[i];

		// Overall parity over everything else, including the Hamming bits
		// This is what lets the decoder tell one flip from two
		placed[0] = ^placed[`SECDED_CODE_BITS-1:1];

		code_next = placed;
	end

	//////////////////////////////////////////////////////////////////////
	// Output register

	// Valid tracks the input one cycle later
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
		end
	end

	// Codeword only loads with a valid word
	always_ff @(posedge clk) begin
		if (valid_in) begin
			data_out <= code_next;
		end
	end

endmodule

//--- verilog/secded_pkg.sv
`include "secded_consts.svh"

package secded_pkg;

	//////////////////////////////////////////////////////////////////////
	// Channel types

	// Plain data word as seen at the top level
	typedef logic [`SECDED_DATA_BITS-1:0] data_t;

	// Codeword
	// Bit 0 is overall even parity of bits 1 to 71
	// Power-of-two positions carry the Hamming parities
	// All other positions carry data bits in ascending order
	typedef logic [`SECDED_CODE_BITS-1:0] codeword_t;

	// Index of one codeword bit
	// 7 bits reach up to 127, so values of 72 and above are out of range
	typedef logic [`SECDED_HAMMING_BITS-1:0] bit_pos_t;

	// How many codeword bits the injector corrupts
	typedef enum logic [1:0] {
		ERR_NONE   = 2'd0,
		ERR_SINGLE = 2'd1,
		ERR_DOUBLE = 2'd2
	} err_count_t;

endpackage

//--- verilog/secded_top.sv
`timescale 1ns/1ns

// Three-stage SEC-DED channel
// Encode, corrupt on demand, decode
// Data at edge N comes out at edge N+3, error controls belong at edge N+1
module secded_top (
	input  logic                   clk,
	input  logic                   arst_n,

	input  secded_pkg::data_t      plaintext,
	input  logic                   plaintext_valid,

	input  secded_pkg::err_count_t numbits,
	input  secded_pkg::bit_pos_t   errpos0,
	input  secded_pkg::bit_pos_t   errpos1,

	output secded_pkg::data_t      decoded,
	output logic                   decoded_valid,
	output logic                   correctable_err,
	output logic                   uncorrectable_err
);

	//////////////////////////////////////////////////////////////////////
	// Encoder

	logic                  codeword_valid;
	secded_pkg::codeword_t codeword;

	secded_encoder encoder (
		.clk       (clk),
		.arst_n    (arst_n),
		.valid_in  (plaintext_valid),
		.data_in   (plaintext),
		.valid_out (codeword_valid),
		.data_out  (codeword)
	);

	//////////////////////////////////////////////////////////////////////
	// Error injection

	logic                  corrupted_valid;
	secded_pkg::codeword_t corrupted;

	// Error controls line up with the codeword, one cycle after the data
	error_injector injector (
		.clk          (clk),
		.arst_n       (arst_n),
		.valid_in     (codeword_valid),
		.codeword_in  (codeword),
		.numbits      (numbits),
		.errpos0      (errpos0),
		.errpos1      (errpos1),
		.valid_out    (corrupted_valid),
		.codeword_out (corrupted)
	);

	//////////////////////////////////////////////////////////////////////
	// Decoder

	secded_decoder decoder (
		.clk               (clk),
		.arst_n            (arst_n),
		.valid_in          (corrupted_valid),
		.data_in           (corrupted),
		.valid_out         (decoded_valid),
		.data_out          (decoded),
		.correctable_err   (correctable_err),
		.uncorrectable_err (uncorrectable_err)
	);

endmodule
